// ==== compile.f ====
hw/sd_hub_pkg.sv
hw/sd_host_mux.sv
hw/spi_shift_engine.sv
hw/sd_reply_port.sv
hw/sd_spi_hub.sv
dv/tb_clock_gen.sv
dv/sd_card_model.sv
dv/sd_spi_hub_assertions.sv
dv/sd_spi_hub_tb.sv

// ==== Makefile ====
# Verilator build and run of the SD card SPI hub testbench

VERILATOR ?= verilator
TOP       ?= sd_spi_hub_tb
RTL_TOP   ?= sd_spi_hub
FLIST     ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall
RTL_SRCS  ?= hw/sd_hub_pkg.sv hw/sd_host_mux.sv hw/spi_shift_engine.sv \
             hw/sd_reply_port.sv hw/sd_spi_hub.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TESTS PASSED" $(LOG) || (echo "simulation failed, see $(LOG)" && exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/sd_spi_hub_tb.sv ====
//////////////////////////////////////////////////
// SD SPI hub testbench: directed tests,
// compare tasks, watchdog and summary
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module sd_spi_hub_tb;
	import sd_hub_pkg::*;

	localparam int unsigned CLK_DIV = 2;
	localparam int N_ZX            = 6;
	localparam int N_AVR           = 4;
	localparam int N_XFER          = N_ZX + N_AVR + 2;
	localparam int XFER_CYCLES     = 16 * CLK_DIV + 20;
	localparam int ACK_CYCLES      = 16 * CLK_DIV + 2;
	localparam int WATCHDOG_CYCLES = N_XFER * XFER_CYCLES + 200;

	logic         fclk;
	logic         rst;
	sd_xfer_req_t zx_req;
	sd_xfer_req_t avr_req;
	sd_xfer_rsp_t zx_rsp;
	sd_xfer_rsp_t avr_rsp;
	logic         zx_cs_val;
	logic         zx_cs_stb;
	logic         avr_lock_claim;
	logic         avr_lock_grant;
	logic         avr_cs_n;
	logic         sdcs_n;
	logic         sdclk;
	logic         sddo;
	logic         sddi;

	int       value_errors;
	int       protocol_errors;
	// byte the card should hand back next
	sd_byte_t echo_exp;

	tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(3)) u_clock_gen (.fclk(fclk), .rst(rst));

	sd_spi_hub #(.CLK_DIV(CLK_DIV)) u_sd_spi_hub (
		.fclk          (fclk          ),
		.rst           (rst           ),
		.zx_req        (zx_req        ),
		.zx_rsp        (zx_rsp        ),
		.zx_cs_val     (zx_cs_val     ),
		.zx_cs_stb     (zx_cs_stb     ),
		.avr_req       (avr_req       ),
		.avr_rsp       (avr_rsp       ),
		.avr_lock_claim(avr_lock_claim),
		.avr_lock_grant(avr_lock_grant),
		.avr_cs_n      (avr_cs_n      ),
		.sdcs_n        (sdcs_n        ),
		.sdclk         (sdclk         ),
		.sddo          (sddo          ),
		.sddi          (sddi          )
	);

	sd_card_model u_card (.sdcs_n(sdcs_n), .sdclk(sdclk), .sddo(sddo), .sddi(sddi));

	//////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////

	task automatic check_byte(input sd_byte_t got, input sd_byte_t exp, input string what);
		if (got !== exp)
		begin
			value_errors++;
			$display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			value_errors++;
			$display("FAIL %0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_cycles(input int got, input int exp, input string what);
		if (got != exp)
		begin
			value_errors++;
			$display("FAIL %0t: %s got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	task automatic wait_grant(input logic level);
		int waited;
		waited = 0;
		while (avr_lock_grant !== level && waited < 20)
		begin
			@(negedge fclk);
			waited++;
		end
		if (avr_lock_grant !== level)
		begin
			protocol_errors++;
			$display("ERROR %0t: avr grant did not go to %b", $time, level);
		end
	endtask

	// full four-phase byte transfer for one host
	task automatic run_transfer(input logic is_avr, input sd_byte_t tx, input logic timed);
		sd_xfer_rsp_t rsp;
		int           waited;
		string        host;
		waited = 0;
		rsp    = '0;
		if (is_avr)
		begin
			host    = "avr";
			avr_req = '{req: 1'b1, data: tx};
		end
		else
		begin
			host   = "zx";
			zx_req = '{req: 1'b1, data: tx};
		end
		while (!rsp.ack && waited < XFER_CYCLES)
		begin
			@(negedge fclk);
			waited++;
			rsp = is_avr ? avr_rsp : zx_rsp;
		end
		if (!rsp.ack)
		begin
			protocol_errors++;
			$display("ERROR %0t: no ack for %s host within %0d cycles", $time, host, waited);
		end
		else
		begin
			if (timed)
				check_cycles(waited, ACK_CYCLES, {host, " req to ack cycles"});
			check_byte(rsp.data, echo_exp, {host, " reply byte"});
			// ack holds as long as req does
			repeat (2)
			begin
				@(negedge fclk);
				rsp = is_avr ? avr_rsp : zx_rsp;
				check_bit(rsp.ack, 1'b1, {host, " ack while req held"});
			end
		end
		echo_exp = tx;
		if (is_avr)
			avr_req.req = 1'b0;
		else
			zx_req.req = 1'b0;
		@(negedge fclk);
		rsp = is_avr ? avr_rsp : zx_rsp;
		check_bit(rsp.ack, 1'b0, {host, " ack one cycle after req drop"});
	endtask

	//////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////

	task automatic check_reset();
		check_bit(sdcs_n, 1'b1, "sdcs_n after reset");
		check_bit(sddo, 1'b1, "sddo after reset");
		check_bit(sdclk, 1'b0, "sdclk after reset");
		check_bit(avr_lock_grant, 1'b0, "grant after reset");
		check_bit(zx_rsp.ack, 1'b0, "zx ack after reset");
		check_bit(avr_rsp.ack, 1'b0, "avr ack after reset");
	endtask

	task automatic test_zx_transfers();
		zx_cs_val = 1'b0;
		zx_cs_stb = 1'b1;
		@(negedge fclk);
		zx_cs_stb = 1'b0;
		check_bit(sdcs_n, 1'b0, "sdcs_n after zx select");
		echo_exp = 8'hff;
		for (int i = 0; i < N_ZX; i++)
			run_transfer(1'b0, sd_byte_t'($urandom()), 1'b1);
	endtask

	task automatic test_avr_lock();
		avr_cs_n       = 1'b1;
		avr_lock_claim = 1'b1;
		wait_grant(1'b1);
		check_bit(sdcs_n, 1'b1, "sdcs_n follows avr_cs_n high");
		avr_cs_n = 1'b0;
		@(negedge fclk);
		check_bit(sdcs_n, 1'b0, "sdcs_n follows avr_cs_n low");
		echo_exp = 8'hff;
		for (int i = 0; i < N_AVR; i++)
			run_transfer(1'b1, sd_byte_t'($urandom()), 1'b1);
		avr_cs_n       = 1'b1;
		avr_lock_claim = 1'b0;
		wait_grant(1'b0);
		check_bit(sdcs_n, 1'b0, "sdcs_n back on zx register");
	endtask

	task automatic test_back_pressure();
		sd_byte_t tx;
		tx             = sd_byte_t'($urandom());
		avr_lock_claim = 1'b1;
		wait_grant(1'b1);
		zx_req = '{req: 1'b1, data: tx};
		repeat (16 * CLK_DIV + 10)
		begin
			@(negedge fclk);
			check_bit(zx_rsp.ack, 1'b0, "zx ack while avr lock held");
		end
		avr_lock_claim = 1'b0;
		// card was deselected while the lock was held
		echo_exp       = 8'hff;
		run_transfer(1'b0, tx, 1'b0);
		check_bit(avr_lock_grant, 1'b0, "grant after lock release");
		run_transfer(1'b0, sd_byte_t'($urandom()), 1'b1);
	endtask

	//////////////////////////////////////////////////
	// main sequence and watchdog
	//////////////////////////////////////////////////

	initial
	begin
		value_errors    = 0;
		protocol_errors = 0;
		echo_exp        = 8'hff;
		zx_req          = '0;
		avr_req         = '0;
		zx_cs_val       = 1'b1;
		zx_cs_stb       = 1'b0;
		avr_lock_claim  = 1'b0;
		avr_cs_n        = 1'b1;
		void'($urandom(32'h795d));
		@(negedge rst);
		@(negedge fclk);
		check_reset();
		test_zx_transfers();
		test_avr_lock();
		test_back_pressure();
		repeat (2) @(negedge fclk);
		$display("summary: %0d value errors, %0d protocol errors, %0d assertion failures",
			value_errors, protocol_errors, u_sd_spi_hub.u_assertions.fail_count);
		if (value_errors == 0 && protocol_errors == 0 &&
			u_sd_spi_hub.u_assertions.fail_count == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge fclk);
		$display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/sd_spi_hub_assertions.sv ====
//////////////////////////////////////////////////
// concurrent checks on the hub top, bound in
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module sd_spi_hub_assertions (
	input logic                     fclk,
	input logic                     rst,
	input sd_hub_pkg::sd_xfer_req_t zx_req,
	input sd_hub_pkg::sd_xfer_req_t avr_req,
	input sd_hub_pkg::sd_xfer_rsp_t zx_rsp,
	input sd_hub_pkg::sd_xfer_rsp_t avr_rsp,
	input logic                     avr_lock_claim,
	input logic                     avr_lock_grant,
	input logic                     sdclk,
	input sd_hub_pkg::eng_state_e   eng_state
);
	import sd_hub_pkg::*;

	// failed checks so far, summed into the testbench totals
	int fail_count = 0;

	// ack only answers an open request
	zx_ack_needs_req: assert property (@(posedge fclk) disable iff (rst)
		$rose(zx_rsp.ack) |-> zx_req.req)
		else
		begin
			fail_count++;
			$error("zx ack rose without zx req");
		end

	avr_ack_needs_req: assert property (@(posedge fclk) disable iff (rst)
		$rose(avr_rsp.ack) |-> avr_req.req)
		else
		begin
			fail_count++;
			$error("avr ack rose without avr req");
		end

	grant_needs_claim: assert property (@(posedge fclk) disable iff (rst)
		$rose(avr_lock_grant) |-> $past(avr_lock_claim))
		else
		begin
			fail_count++;
			$error("avr grant rose without claim");
		end

	sdclk_low_when_idle: assert property (@(posedge fclk) disable iff (rst)
		(eng_state == eng_idle) |-> !sdclk)
		else
		begin
			fail_count++;
			$error("sdclk high while shift engine idle");
		end

endmodule

bind sd_spi_hub sd_spi_hub_assertions u_assertions (
	.fclk          (fclk                   ),
	.rst           (rst                    ),
	.zx_req        (zx_req                 ),
	.avr_req       (avr_req                ),
	.zx_rsp        (zx_rsp                 ),
	.avr_rsp       (avr_rsp                ),
	.avr_lock_claim(avr_lock_claim         ),
	.avr_lock_grant(avr_lock_grant         ),
	.sdclk         (sdclk                  ),
	.eng_state     (u_shift_engine.state_q )
);

`default_nettype wire

// ==== dv/sd_card_model.sv ====
//////////////////////////////////////////////////
// behavioral SD card SPI slave, mode 0
// replies with the previous byte received
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module sd_card_model (
	input  logic sdcs_n,
	input  logic sdclk,
	input  logic sddo,
	output logic sddi
);

	logic [7:0] rx_sh;
	logic [7:0] tx_sh;
	logic [2:0] rx_cnt;

	// sample on rising sdclk
	always @(posedge sdclk or posedge sdcs_n)
	begin
		if (sdcs_n)
			rx_cnt <= '0;
		else
		begin
			rx_sh  <= {rx_sh[6:0], sddo};
			rx_cnt <= rx_cnt + 3'd1;
		end
	end

	// shift on falling sdclk; after a full byte reload with it
	always @(negedge sdclk or posedge sdcs_n)
	begin
		if (sdcs_n)
			tx_sh <= 8'hff;
		else if (rx_cnt == 3'd0)
			tx_sh <= rx_sh;
		else
			tx_sh <= {tx_sh[6:0], 1'b1};
	end

	assign sddi = tx_sh[7];

endmodule

`default_nettype wire

// ==== dv/tb_clock_gen.sv ====
//////////////////////////////////////////////////
// testbench clock and synchronous reset source
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD_NS    = 100,
	parameter int RESET_CYCLES = 3
) (
	output logic fclk,
	output logic rst
);

	initial
	begin
		fclk = 1'b0;
		forever #(PERIOD_NS / 2) fclk = ~fclk;
	end

	// release on a falling edge, clear of the sampling edge
	initial
	begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge fclk);
		@(negedge fclk);
		rst = 1'b0;
	end

endmodule

`default_nettype wire

// ==== hw/sd_spi_hub.sv ====
//////////////////////////////////////////////////
// SD card SPI hub top: host mux, shifter
// and reply port wired to the card pins
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module sd_spi_hub #(
	parameter int unsigned CLK_DIV = 2
) (
	input  logic                     fclk,
	input  logic                     rst,
	// zx port side
	input  sd_hub_pkg::sd_xfer_req_t zx_req,
	output sd_hub_pkg::sd_xfer_rsp_t zx_rsp,
	input  logic                     zx_cs_val,
	input  logic                     zx_cs_stb,
	// avr side
	input  sd_hub_pkg::sd_xfer_req_t avr_req,
	output sd_hub_pkg::sd_xfer_rsp_t avr_rsp,
	input  logic                     avr_lock_claim,
	output logic                     avr_lock_grant,
	input  logic                     avr_cs_n,
	// card pins
	output logic                     sdcs_n,
	output logic                     sdclk,
	output logic                     sddo,
	input  logic                     sddi
);
	import sd_hub_pkg::*;

	sd_cmd_t  cmd;
	sd_done_t done;

	sd_host_mux u_host_mux (
		.fclk          (fclk          ),
		.rst           (rst           ),
		.zx_req        (zx_req        ),
		.avr_req       (avr_req       ),
		.zx_cs_val     (zx_cs_val     ),
		.zx_cs_stb     (zx_cs_stb     ),
		.avr_lock_claim(avr_lock_claim),
		.avr_cs_n      (avr_cs_n      ),
		.zx_ack        (zx_rsp.ack    ),
		.avr_ack       (avr_rsp.ack   ),
		.avr_lock_grant(avr_lock_grant),
		.sdcs_n        (sdcs_n        ),
		.cmd           (cmd           )
	);

	spi_shift_engine #(.CLK_DIV(CLK_DIV)) u_shift_engine (
		.fclk (fclk ),
		.rst  (rst  ),
		.cmd  (cmd  ),
		.sddi (sddi ),
		.sdclk(sdclk),
		.sddo (sddo ),
		.done (done )
	);

	sd_reply_port u_reply_port (
		.fclk      (fclk       ),
		.rst       (rst        ),
		.done      (done       ),
		.zx_req_on (zx_req.req ),
		.avr_req_on(avr_req.req),
		.zx_rsp    (zx_rsp     ),
		.avr_rsp   (avr_rsp    )
	);

endmodule

`default_nettype wire

// ==== hw/sd_reply_port.sv ====
//////////////////////////////////////////////////
// SD hub output side: per host ack and
// received byte hold
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module sd_reply_port (
	input  logic                     fclk,
	input  logic                     rst,
	input  sd_hub_pkg::sd_done_t     done,
	input  logic                     zx_req_on,
	input  logic                     avr_req_on,
	output sd_hub_pkg::sd_xfer_rsp_t zx_rsp,
	output sd_hub_pkg::sd_xfer_rsp_t avr_rsp
);
	import sd_hub_pkg::*;

	// index 0 is zx, index 1 is avr
	logic [1:0] ack_q;
	logic [1:0] req_on;
	sd_byte_t   data_q [2];

	assign req_on = {avr_req_on, zx_req_on};

	always_ff @(posedge fclk)
	begin
		if (rst)
			ack_q <= '0;
		else
		begin
			for (int i = 0; i < 2; i++)
			begin
				if (done.done && (done.owner == 1'(i)))
					ack_q[i] <= 1'b1;
				// host dropped req, close the handshake
				else if (ack_q[i] && !req_on[i])
					ack_q[i] <= 1'b0;
			end
		end
	end

	always_ff @(posedge fclk)
	begin
		if (done.done)
			data_q[done.owner] <= done.data;
	end

	assign zx_rsp  = '{ack: ack_q[0], data: data_q[0]};
	assign avr_rsp = '{ack: ack_q[1], data: data_q[1]};

endmodule

`default_nettype wire

// ==== hw/spi_shift_engine.sv ====
//////////////////////////////////////////////////
// SPI mode 0 byte shifter, MSB first,
// sdclk half period of CLK_DIV fclk cycles
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module spi_shift_engine #(
	parameter int unsigned CLK_DIV = 2
) (
	input  logic                 fclk,
	input  logic                 rst,
	input  sd_hub_pkg::sd_cmd_t  cmd,
	input  logic                 sddi,
	output logic                 sdclk,
	output logic                 sddo,
	output sd_hub_pkg::sd_done_t done
);
	import sd_hub_pkg::*;

	localparam div_cnt_t DIV_LAST = div_cnt_t'(CLK_DIV - 1);

	eng_state_e state_q;
	div_cnt_t   div_q;
	logic [2:0] bit_cnt_q;
	logic       done_q;
	logic       owner_q;
	logic       rx_bit_q;
	sd_byte_t   sh_q;

	logic rise;
	logic fall;

	// start cycle counts as the first low cycle
	assign rise = ((state_q == eng_idle) && cmd.start && (CLK_DIV == 1)) ||
	              ((state_q == eng_low) && (div_q == DIV_LAST));
	assign fall = (state_q == eng_high) && (div_q == DIV_LAST);

	always_ff @(posedge fclk)
	begin
		if (rst)
		begin
			state_q   <= eng_idle;
			sdclk     <= 1'b0;
			div_q     <= '0;
			bit_cnt_q <= '0;
			done_q    <= 1'b0;
		end
		else
		begin
			done_q <= 1'b0;
			case (state_q)
				eng_idle:
					if (cmd.start)
					begin
						bit_cnt_q <= '0;
						if (rise)
						begin
							sdclk   <= 1'b1;
							div_q   <= '0;
							state_q <= eng_high;
						end
						else
						begin
							div_q   <= div_cnt_t'(1);
							state_q <= eng_low;
						end
					end
				eng_low:
					if (rise)
					begin
						sdclk   <= 1'b1;
						div_q   <= '0;
						state_q <= eng_high;
					end
					else
						div_q <= div_q + div_cnt_t'(1);
				eng_high:
					if (fall)
					begin
						sdclk     <= 1'b0;
						div_q     <= '0;
						bit_cnt_q <= bit_cnt_q + 3'd1;
						if (bit_cnt_q == 3'd7)
						begin
							done_q  <= 1'b1;
							state_q <= eng_idle;
						end
						else
							state_q <= eng_low;
					end
					else
						div_q <= div_q + div_cnt_t'(1);
				default:
					state_q <= eng_idle;
			endcase
		end
	end

	// shared shift register, tx out at the top, rx in at the bottom
	always_ff @(posedge fclk)
	begin
		if ((state_q == eng_idle) && cmd.start)
		begin
			sh_q    <= cmd.data;
			owner_q <= cmd.owner;
		end
		if (rise)
			rx_bit_q <= sddi;
		if (fall)
			sh_q <= {sh_q[6:0], rx_bit_q};
	end

	// first bit is already on the line in the start cycle
	assign sddo = (state_q == eng_idle) ? (cmd.start ? cmd.data[7] : 1'b1) : sh_q[7];
	assign done = '{done: done_q, data: sh_q, owner: owner_q};

endmodule

`default_nettype wire

// ==== hw/sd_host_mux.sv ====
//////////////////////////////////////////////////
// SD hub input side: avr lock, zx chip-select
// register and owner selection of byte requests
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module sd_host_mux (
	input  logic                     fclk,
	input  logic                     rst,
	input  sd_hub_pkg::sd_xfer_req_t zx_req,
	input  sd_hub_pkg::sd_xfer_req_t avr_req,
	input  logic                     zx_cs_val,
	input  logic                     zx_cs_stb,
	input  logic                     avr_lock_claim,
	input  logic                     avr_cs_n,
	input  logic                     zx_ack,
	input  logic                     avr_ack,
	output logic                     avr_lock_grant,
	output logic                     sdcs_n,
	output sd_hub_pkg::sd_cmd_t      cmd
);
	import sd_hub_pkg::*;

	mux_state_e state_q;
	logic       grant_q;
	logic       zx_cs_q;
	logic       start_q;
	logic       owner_q;
	sd_byte_t   data_q;

	logic zx_busy;
	logic avr_busy;
	logic zx_take;
	logic avr_take;
	logic own_ack;
	logic own_req;

	always_comb
	begin
		zx_busy  = (state_q != mux_idle) && !owner_q;
		avr_busy = (state_q != mux_idle) && owner_q;
		// zx yields while the avr is claiming, avr only runs under the lock
		zx_take  = (state_q == mux_idle) && !grant_q && !avr_lock_claim && zx_req.req;
		avr_take = (state_q == mux_idle) && grant_q && avr_lock_claim && avr_req.req;
		own_ack  = owner_q ? avr_ack : zx_ack;
		own_req  = owner_q ? avr_req.req : zx_req.req;
	end

	//////////////////////////////////////////////////
	// lock and chip select
	//////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (rst)
		begin
			grant_q <= 1'b0;
			zx_cs_q <= 1'b1;
		end
		else
		begin
			if (!grant_q && avr_lock_claim && !zx_busy)
				grant_q <= 1'b1;
			else if (grant_q && !avr_lock_claim && !avr_busy)
				grant_q <= 1'b0;

			if (zx_cs_stb)
				zx_cs_q <= zx_cs_val;
		end
	end

	assign avr_lock_grant = grant_q;
	assign sdcs_n         = grant_q ? avr_cs_n : zx_cs_q;

	//////////////////////////////////////////////////
	// request FSM
	//////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (rst)
		begin
			state_q <= mux_idle;
			start_q <= 1'b0;
		end
		else
		begin
			start_q <= zx_take || avr_take;
			case (state_q)
				mux_idle:
					if (zx_take || avr_take)
						state_q <= mux_busy;
				mux_busy:
					if (own_ack)
						state_q <= mux_wait_drop;
				// end of four-phase cycle
				mux_wait_drop:
					if (!own_req)
						state_q <= mux_idle;
				default:
					state_q <= mux_idle;
			endcase
		end
	end

	// byte and owner latched with the accepted request
	always_ff @(posedge fclk)
	begin
		if (zx_take || avr_take)
		begin
			owner_q <= avr_take;
			data_q  <= avr_take ? avr_req.data : zx_req.data;
		end
	end

	assign cmd = '{start: start_q, data: data_q, owner: owner_q};

endmodule

`default_nettype wire

// ==== hw/sd_hub_pkg.sv ====
//////////////////////////////////////////////////
// SD card SPI hub shared types
// byte and divider widths, host and engine structs, FSM states
//////////////////////////////////////////////////
`default_nettype none

package sd_hub_pkg;

	typedef logic [7:0] sd_byte_t;
	typedef logic [7:0] div_cnt_t;

	// host side request and answer
	typedef struct packed {
		logic     req;
		sd_byte_t data;
	} sd_xfer_req_t;

	typedef struct packed {
		logic     ack;
		sd_byte_t data;
	} sd_xfer_rsp_t;

	// owner is 0 for zx, 1 for avr
	typedef struct packed {
		logic     start;
		sd_byte_t data;
		logic     owner;
	} sd_cmd_t;

	typedef struct packed {
		logic     done;
		sd_byte_t data;
		logic     owner;
	} sd_done_t;

	typedef enum logic [1:0] {mux_idle, mux_busy, mux_wait_drop} mux_state_e;
	typedef enum logic [1:0] {eng_idle, eng_low, eng_high} eng_state_e;

endpackage

`default_nettype wire
